//--- project.f
+incdir+hw
hw/nocPkg.sv
hw/flitFifo.sv
hw/lbdrRoute.sv
hw/flitDispatch.sv
hw/routerInputPort.sv
bench/clockGen.sv
bench/routerInputPortTb.sv

//--- bench/routeCases.txt
# C routeBits connBits nodeAddr (hex), routeBits {rsw,rse,rws,rwn,res,ren,rnw,rne}, conn {S,W,E,N}
# P kind body expectedPort; kind 0 head 1 body 2 tail 3 headtail; port 0N 1E 2W 3S 4L 7 dropped
# Node x=1 y=1, vertical first on diagonals
C C3 F 5
# Straight destinations and local, one headtail each
P 3 1501 0
P 3 6502 1
P 3 4503 2
P 3 9504 3
P 3 5505 4
# South-west packet goes south
P 0 8510 3
P 1 BEEF 3
P 1 1234 3
P 2 CAFE 3
# North-east packet goes north
P 0 2511 0
P 2 0F0F 0
# South-east and north-west single flits
P 3 F512 3
P 3 0513 0
# Same node, horizontal first on diagonals
C 3C F 5
P 0 8520 2
P 1 A5A5 2
P 2 5A5A 2
P 3 2521 1
P 3 F522 1
P 0 0523 2
P 2 7777 2
P 3 D524 3
# East link disconnected, east-bound packets dropped
C C3 D 5
P 0 6530 7
P 1 1111 7
P 2 2222 7
P 3 2531 0
P 3 6532 7
P 3 F533 3
P 0 9534 3
P 1 3333 3
P 2 4444 3

//--- bench/routerInputPortTb.sv
// Run from the project root (reads bench/routeCases.txt); at most 64 records and 64 flits per port
`timescale 1ns/1ps
`default_nettype none
`include "noc_macros.svh"

module routerInputPortTb;

  import nocPkg::*;

  localparam int MaxRec = 64;

  logic                       clk;
  logic                       rst;
  logic [7:0]                 routeBits;
  logic [3:0]                 connBits;
  logic [`NOC_ADDR_WIDTH-1:0] nodeAddr;
  logic                       inValid;
  logic                       inReady;
  flitKindT                   inKind;
  flitBodyU                   inBody;
  logic [4:0]                 outValid;
  logic [4:0]                 outReady;
  flitKindT                   outKind;
  flitBodyU                   outBody;
  logic [7:0]                 dropCount;

  // Records from the cases file, config or flit
  logic   recIsCfg [0:MaxRec-1];
  integer recA [0:MaxRec-1];
  integer recB [0:MaxRec-1];
  integer recC [0:MaxRec-1];
  integer recCount;
  integer flitCount;
  integer cfgCount;

  // Expected flits per port as {kind, body}
  logic [`NOC_DATA_WIDTH+1:0] expMem [0:4][0:63];
  integer expWr [0:4];
  integer expRd [0:4];
  integer expDrops;

  integer errorCount;
  integer flitsChecked;
  integer cycleCount;
  integer cycleLimit;
  integer seed;
  integer rnd;
  integer monPort;
  integer fd;
  integer ch;
  integer idx;
  logic   configured;

  clockGen clockGen_inst (
    .clk (clk)
  );

  routerInputPort routerInputPort_inst (
    .clk       (clk),
    .rst       (rst),
    .routeBits (routeBits),
    .connBits  (connBits),
    .nodeAddr  (nodeAddr),
    .inValid   (inValid),
    .inReady   (inReady),
    .inKind    (inKind),
    .inBody    (inBody),
    .outValid  (outValid),
    .outReady  (outReady),
    .outKind   (outKind),
    .outBody   (outBody),
    .dropCount (dropCount)
  );

  task automatic checkValue(input string name, input logic [31:0] got,
                            input logic [31:0] expected);
    if (got !== expected) begin
      errorCount = errorCount + 1;
      $display("Fail %s: got %h, expected %h at %0t", name, got, expected, $time);
    end
  endtask

  // Rest of the current line, comments included
  task automatic skipLine();
    integer c;
    c = $fgetc(fd);
    while (c != "\n" && c != -1) begin
      c = $fgetc(fd);
    end
  endtask

  // C lines carry config, P lines carry one flit each
  task automatic loadCases();
    integer a;
    integer b;
    integer c;
    integer code;
    ch = $fgetc(fd);
    while (ch != -1) begin
      if (ch == "C" || ch == "P") begin
        code = $fscanf(fd, " %h %h %h", a, b, c);
        if (code != 3 || recCount >= MaxRec) begin
          $display("Cases file record %0d is malformed or beyond the limit", recCount);
          errorCount = errorCount + 1;
        end else begin
          recIsCfg[recCount] = (ch == "C");
          recA[recCount] = a;
          recB[recCount] = b;
          recC[recCount] = c;
          if (ch == "C") cfgCount = cfgCount + 1;
          else flitCount = flitCount + 1;
          recCount = recCount + 1;
        end
        skipLine();
      end else if (ch == "#") begin
        skipLine();
      end
      ch = $fgetc(fd);
    end
  endtask

  task automatic clearExpected();
    integer p;
    for (p = 0; p < 5; p++) begin
      expWr[p] = 0;
      expRd[p] = 0;
    end
    expDrops = 0;
  endtask

  function automatic logic allEmpty();
    integer p;
    logic e;
    e = 1'b1;
    for (p = 0; p < 5; p++) begin
      if (expWr[p] != expRd[p]) e = 1'b0;
    end
    return e;
  endfunction

  // Called at time zero or just after a rising edge; rst spans 3 rising edges
  task automatic applyReset(input logic [7:0] rb, input logic [3:0] cb,
                            input logic [`NOC_ADDR_WIDTH-1:0] na);
    rst = 1'b1;
    routeBits = rb;
    connBits = cb;
    nodeAddr = na;
    inValid = 1'b0;
    clearExpected();
    repeat (3) @(posedge clk);
    #1 rst = 1'b0;
    // Idle state right after reset
    @(negedge clk);
    checkValue("outValid", outValid, 5'b0);
    checkValue("inReady", inReady, 1'b1);
    checkValue("dropCount", dropCount, 8'd0);
    @(posedge clk);
    #1;
  endtask

  // Port 7 in the file means the packet must be dropped
  task automatic queueExpected(input integer kind, input integer body, input integer port);
    if (port == 7) begin
      if (kind == 0 || kind == 3) expDrops = expDrops + 1;
    end else begin
      expMem[port][expWr[port]] = {kind[1:0], body[`NOC_DATA_WIDTH-1:0]};
      expWr[port] = expWr[port] + 1;
    end
  endtask

  // Holds the flit until inReady is seen high before a rising edge
  task automatic sendFlit(input integer kind, input integer body);
    logic taken;
    taken = 1'b0;
    inValid = 1'b1;
    inKind = flitKindT'(kind[1:0]);
    inBody.data = body[`NOC_DATA_WIDTH-1:0];
    while (!taken) begin
      @(negedge clk);
      taken = inReady;
      @(posedge clk);
      #1;
    end
    inValid = 1'b0;
  endtask

  // Wait for every expected flit, then for the last drops to pass
  task automatic drainPackets();
    integer waitCnt;
    while (!allEmpty()) begin
      @(posedge clk);
      #1;
    end
    waitCnt = 0;
    while (dropCount != expDrops[7:0] && waitCnt < 16) begin
      @(posedge clk);
      #1;
      waitCnt = waitCnt + 1;
    end
    checkValue("dropCount", dropCount, expDrops);
  endtask

  // Random back-pressure, about half the cycles ready per port
  always @(posedge clk) begin
    #1;
    rnd = $random(seed);
    outReady = rnd[4:0];
  end

  // Output transfers, sampled mid-cycle where everything is settled
  always @(negedge clk) begin
    if (!rst) begin
      checkValue("outValid onehot", ((outValid & (outValid - 5'd1)) == 5'd0), 1'b1);
      for (monPort = 0; monPort < 5; monPort++) begin
        if (outValid[monPort] && outReady[monPort]) begin
          if (expRd[monPort] == expWr[monPort]) begin
            $display("Unexpected flit on port %0d with body %h", monPort, outBody.data);
            errorCount = errorCount + 1;
          end else begin
            checkValue($sformatf("outKind port %0d", monPort), outKind,
                       expMem[monPort][expRd[monPort]][`NOC_DATA_WIDTH+1:`NOC_DATA_WIDTH]);
            checkValue($sformatf("outBody port %0d", monPort), outBody.data,
                       expMem[monPort][expRd[monPort]][`NOC_DATA_WIDTH-1:0]);
            expRd[monPort] = expRd[monPort] + 1;
            flitsChecked = flitsChecked + 1;
          end
        end
      end
    end
  end

  // Cycle budget of 40 per flit plus room for each reset
  always @(posedge clk) begin
    cycleCount = cycleCount + 1;
    if (cycleLimit > 0 && cycleCount > cycleLimit) begin
      $display("Timeout after %0d cycles with flits still outstanding", cycleCount);
      $display("sim failed");
      $finish;
    end
  end

  initial begin
    rst = 1'b1;
    routeBits = 8'h00;
    connBits = 4'h0;
    nodeAddr = '0;
    inValid = 1'b0;
    inKind = HEADER;
    inBody = '0;
    outReady = 5'b0;
    seed = 32'hb16f2ef5;
    errorCount = 0;
    flitsChecked = 0;
    cycleCount = 0;
    cycleLimit = 0;
    recCount = 0;
    flitCount = 0;
    cfgCount = 0;
    configured = 1'b0;
    clearExpected();
    fd = $fopen("bench/routeCases.txt", "r");
    if (fd == 0) begin
      $display("Could not open the cases file bench/routeCases.txt");
      errorCount = errorCount + 1;
    end else begin
      loadCases();
      $fclose(fd);
      cycleLimit = 40 * flitCount + 16 * cfgCount + 16;
      for (idx = 0; idx < recCount; idx++) begin
        if (recIsCfg[idx]) begin
          // New configuration only takes effect through a reset
          if (configured) drainPackets();
          applyReset(recA[idx][7:0], recB[idx][3:0], recC[idx][`NOC_ADDR_WIDTH-1:0]);
          configured = 1'b1;
        end else begin
          queueExpected(recA[idx], recB[idx], recC[idx]);
          sendFlit(recA[idx], recB[idx]);
        end
      end
      drainPackets();
    end
    $display("Done: %0d flits checked, %0d errors", flitsChecked, errorCount);
    if (errorCount == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- bench/clockGen.sv
// Free-running bench clock with a 4 ns period; starts low, first rising edge at 2 ns
`timescale 1ns/1ps
`default_nettype none

module clockGen (
  output logic clk
);

  // Half period of 2 ns
  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

endmodule

`default_nettype wire

//--- hw/routerInputPort.sv
// One input channel only; no crossbar, arbitration, virtual channels or credits
`timescale 1ns/1ps
`default_nettype none
`include "noc_macros.svh"

module routerInputPort (
  input  wire                        clk,
  input  wire                        rst,
  // Configuration, sampled while rst is high
  input  wire  [7:0]                 routeBits,
  input  wire  [3:0]                 connBits,
  input  wire  [`NOC_ADDR_WIDTH-1:0] nodeAddr,
  // Incoming flits
  input  wire                        inValid,
  output logic                       inReady,
  input  wire  nocPkg::flitKindT     inKind,
  input  wire  nocPkg::flitBodyU     inBody,
  // Output channels in N, E, W, S, L bit order
  output logic [4:0]                 outValid,
  input  wire  [4:0]                 outReady,
  output nocPkg::flitKindT           outKind,
  output nocPkg::flitBodyU           outBody,
  output logic [7:0]                 dropCount
);

  import nocPkg::*;

  // FIFO to route stage
  logic       fifoValid;
  logic       fifoReady;
  flitKindT   fifoKind;
  flitBodyU   fifoBody;

  // Route stage to dispatch
  logic       rtValid;
  logic       rtReady;
  flitKindT   rtKind;
  flitBodyU   rtBody;
  logic [4:0] rtDir;

  // Input buffer
  flitFifo flitFifo_inst (
    .clk      (clk),
    .rst      (rst),
    .inValid  (inValid),
    .inReady  (inReady),
    .inKind   (inKind),
    .inBody   (inBody),
    .outValid (fifoValid),
    .outReady (fifoReady),
    .outKind  (fifoKind),
    .outBody  (fifoBody)
  );

  // Header decode and per-packet direction, one register stage
  lbdrRoute lbdrRoute_inst (
    .clk       (clk),
    .rst       (rst),
    .routeBits (routeBits),
    .connBits  (connBits),
    .nodeAddr  (nodeAddr),
    .inValid   (fifoValid),
    .inReady   (fifoReady),
    .inKind    (fifoKind),
    .inBody    (fifoBody),
    .outValid  (rtValid),
    .outReady  (rtReady),
    .outKind   (rtKind),
    .outBody   (rtBody),
    .outDir    (rtDir)
  );

  // Output steering and drop counting
  flitDispatch flitDispatch_inst (
    .clk       (clk),
    .rst       (rst),
    .inValid   (rtValid),
    .inReady   (rtReady),
    .inKind    (rtKind),
    .inBody    (rtBody),
    .inDir     (rtDir),
    .outValid  (outValid),
    .outReady  (outReady),
    .outKind   (outKind),
    .outBody   (outBody),
    .dropCount (dropCount)
  );

endmodule

`default_nettype wire

//--- hw/flitDispatch.sv
// Data path is combinational; inReady follows outReady of the chosen port, drops never stall
`timescale 1ns/1ps
`default_nettype none

module flitDispatch (
  input  wire                    clk,
  input  wire                    rst,
  // Routed flit from the route stage
  input  wire                    inValid,
  output logic                   inReady,
  input  wire  nocPkg::flitKindT inKind,
  input  wire  nocPkg::flitBodyU inBody,
  input  wire  [4:0]             inDir,
  // Five output channels, shared kind and body
  output logic [4:0]             outValid,
  input  wire  [4:0]             outReady,
  output nocPkg::flitKindT       outKind,
  output nocPkg::flitBodyU       outBody,
  // Dropped packets, saturating
  output logic [7:0]             dropCount
);

  import nocPkg::*;

  logic dropped;
  logic accept;
  logic isHead;
  // Set between a header and its tail
  logic inPkt;

  // Zero direction means the header found no permitted port
  assign dropped = (inDir == '0);

  // Valid only toward the selected port
  assign outValid = {5{inValid}} & inDir;

  // Ready from the selected port, always ready when dropping
  assign inReady = dropped || ((outReady & inDir) != '0);

  assign outKind = inKind;
  assign outBody = inBody;

  assign accept = inValid && inReady;
  assign isHead = (inKind == HEADER) || (inKind == HEADTAIL);

  always_ff @(posedge clk) begin
    if (rst) begin
      dropCount <= '0;
      inPkt     <= 1'b0;
    end else begin
      // One count per dropped packet, taken at its header
      if (accept && isHead && dropped && (dropCount != 8'hFF)) begin
        dropCount <= dropCount + 1'b1;
      end
      // Packet framing
      if (accept) begin
        case (inKind)
          HEADER:         inPkt <= 1'b1;
          TAIL, HEADTAIL: inPkt <= 1'b0;
          default:        inPkt <= inPkt;
        endcase
      end
    end
  end

  // Body and tail flits only inside an open packet
  assert property (@(posedge clk) disable iff (rst)
    (inValid && ((inKind == BODY) || (inKind == TAIL))) |-> inPkt)
    else $error("flitDispatch: body or tail outside a packet");

  // A stalled flit keeps its kind and direction until it leaves
  assert property (@(posedge clk) disable iff (rst)
    (inValid && !inReady) |=> (inValid && $stable(inDir) && $stable(inKind)))
    else $error("flitDispatch: stalled flit changed");

endmodule

`default_nettype wire

//--- hw/lbdrRoute.sv
// Minimal LBDR, no deroutes or forks; configuration is sampled only while rst is high
`timescale 1ns/1ps
`default_nettype none
`include "noc_macros.svh"

module lbdrRoute (
  input  wire                        clk,
  input  wire                        rst,
  // Configuration, captured during reset
  input  wire  [7:0]                 routeBits,
  input  wire  [3:0]                 connBits,
  input  wire  [`NOC_ADDR_WIDTH-1:0] nodeAddr,
  // Upstream flit
  input  wire                        inValid,
  output logic                       inReady,
  input  wire  nocPkg::flitKindT     inKind,
  input  wire  nocPkg::flitBodyU     inBody,
  // Downstream flit with its direction
  output logic                       outValid,
  input  wire                        outReady,
  output nocPkg::flitKindT           outKind,
  output nocPkg::flitBodyU           outBody,
  output logic [4:0]                 outDir
);

  import nocPkg::*;

  localparam int AddrW = `NOC_ADDR_WIDTH;
  localparam int HalfW = AddrW / 2;

  // Configuration registers
  logic [7:0]       rxy;
  logic [3:0]       cx;
  logic [AddrW-1:0] curAddr;

  // Routing bits, two per output port
  logic             rne;
  logic             rnw;
  logic             ren;
  logic             res;
  logic             rwn;
  logic             rws;
  logic             rse;
  logic             rsw;

  // Connectivity bits, one per mesh port
  logic             cn;
  logic             ce;
  logic             cw;
  logic             cs;

  // XY coordinates of this node and of the destination
  logic [HalfW-1:0] xCur;
  logic [HalfW-1:0] yCur;
  logic [HalfW-1:0] xDst;
  logic [HalfW-1:0] yDst;

  // Quadrant comparison
  logic             goN;
  logic             goE;
  logic             goW;
  logic             goS;

  logic [4:0]       hdrDir;
  logic             isHead;
  logic             accept;

  assign {rsw, rse, rws, rwn, res, ren, rnw, rne} = rxy;
  assign {cs, cw, ce, cn} = cx;

  assign xCur = curAddr[HalfW-1:0];
  assign yCur = curAddr[AddrW-1:HalfW];
  assign xDst = inBody.hdr.dst[HalfW-1:0];
  assign yDst = inBody.hdr.dst[AddrW-1:HalfW];

  // Configuration load, held for the rest of the run
  always_ff @(posedge clk) begin
    if (rst) begin
      rxy     <= routeBits;
      cx      <= connBits;
      curAddr <= nodeAddr;
    end
  end

  // North means smaller y, east means larger x
  assign goN = (yDst < yCur);
  assign goE = (xCur < xDst);
  assign goW = (xDst < xCur);
  assign goS = (yCur < yDst);

  // LBDR equations, each mesh port gated by its connectivity bit
  always_comb begin
    hdrDir         = '0;
    hdrDir[PORT_N] = ((goN & ~goE & ~goW) | (goN & goE & rne) | (goN & goW & rnw)) & cn;
    hdrDir[PORT_E] = ((goE & ~goN & ~goS) | (goE & goN & ren) | (goE & goS & res)) & ce;
    hdrDir[PORT_W] = ((goW & ~goN & ~goS) | (goW & goN & rwn) | (goW & goS & rws)) & cw;
    // South-west term takes the west comparison
    hdrDir[PORT_S] = ((goS & ~goE & ~goW) | (goS & goE & rse) | (goS & goW & rsw)) & cs;
    // Local only when the destination is this node
    hdrDir[PORT_L] = ~goN & ~goE & ~goW & ~goS;
  end

  // Single-entry pipeline register, one flit per cycle when drained
  assign inReady = !outValid || outReady;
  assign accept  = inValid && inReady;
  assign isHead  = (inKind == HEADER) || (inKind == HEADTAIL);

  always_ff @(posedge clk) begin
    if (rst) begin
      outValid <= 1'b0;
      outDir   <= '0;
    end else begin
      if (accept) begin
        outValid <= 1'b1;
      end else if (outReady) begin
        outValid <= 1'b0;
      end
      // Direction changes only on a header, body and tail reuse it
      if (accept && isHead) begin
        outDir <= hdrDir;
      end
    end
  end

  // Flit payload
  always_ff @(posedge clk) begin
    if (accept) begin
      outKind <= inKind;
      outBody <= inBody;
    end
  end

  // Routing bits must never pick two ports for one header
  assert property (@(posedge clk) disable iff (rst) (accept && isHead) |=> $onehot0(outDir))
    else $error("lbdrRoute: header direction not one-hot");

endmodule

`default_nettype wire

//--- hw/flitFifo.sv
// Depth from NOC_FIFO_DEPTH (power of two, >= 2); a full FIFO accepts only while its head leaves
`timescale 1ns/1ps
`default_nettype none
`include "noc_macros.svh"

module flitFifo (
  input  wire                    clk,
  input  wire                    rst,
  // Write side
  input  wire                    inValid,
  output logic                   inReady,
  input  wire  nocPkg::flitKindT inKind,
  input  wire  nocPkg::flitBodyU inBody,
  // Read side
  output logic                   outValid,
  input  wire                    outReady,
  output nocPkg::flitKindT       outKind,
  output nocPkg::flitBodyU       outBody
);

  import nocPkg::*;

  localparam int Depth = `NOC_FIFO_DEPTH;
  localparam int PtrW  = $clog2(Depth);

  // Storage, one kind and one body per entry
  flitKindT        kindMem [Depth];
  flitBodyU        bodyMem [Depth];

  // Pointers wrap naturally at the power-of-two depth
  logic [PtrW-1:0] wrPtr;
  logic [PtrW-1:0] rdPtr;
  // Occupancy, one bit wider than the pointers
  logic [PtrW:0]   count;

  logic            full;
  logic            empty;
  logic            wrEn;
  logic            rdEn;

  assign full  = (count == (PtrW+1)'(Depth));
  assign empty = (count == '0);

  // Full but draining still takes a new flit
  assign inReady  = !full || outReady;
  assign outValid = !empty;

  // Handshakes on both sides
  assign wrEn = inValid && inReady;
  assign rdEn = outValid && outReady;

  // Head entry straight from the storage registers
  assign outKind = kindMem[rdPtr];
  assign outBody = bodyMem[rdPtr];

  // Entry write
  always_ff @(posedge clk) begin
    if (wrEn) begin
      kindMem[wrPtr] <= inKind;
      bodyMem[wrPtr] <= inBody;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge clk) begin
    if (rst) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (wrEn) begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (rdEn) begin
        rdPtr <= rdPtr + 1'b1;
      end
      // Simultaneous read and write leaves the count alone
      case ({wrEn, rdEn})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Overflow or underflow would push the occupancy past the depth
  assert property (@(posedge clk) disable iff (rst) count <= (PtrW+1)'(Depth))
    else $error("flitFifo: occupancy out of range");

  // Pointer distance must agree with the occupancy
  assert property (@(posedge clk) disable iff (rst)
    (wrPtr - rdPtr) == count[PtrW-1:0])
    else $error("flitFifo: pointers disagree with occupancy");

endmodule

`default_nettype wire

//--- hw/nocPkg.sv
// Flit kinds and body layout shared by RTL and bench; body width is fixed by noc_macros.svh
`default_nettype none
`include "noc_macros.svh"

package nocPkg;

  // Flit kinds carried next to every body
  // HEADTAIL is a complete packet in one flit
  typedef enum logic [1:0] {
    HEADER   = 2'b00,
    BODY     = 2'b01,
    TAIL     = 2'b10,
    HEADTAIL = 2'b11
  } flitKindT;

  // Header view of the flit body
  // Destination sits in the top bits
  typedef struct packed {
    logic [`NOC_ADDR_WIDTH-1:0]                     dst;
    logic [`NOC_ADDR_WIDTH-1:0]                     src;
    logic [`NOC_DATA_WIDTH-2*`NOC_ADDR_WIDTH-1:0]   tag;
  } flitHdrT;

  // Same word, read as addresses in a header and as data otherwise
  typedef union packed {
    flitHdrT                    hdr;
    logic [`NOC_DATA_WIDTH-1:0] data;
  } flitBodyU;

  // Bit positions in the 5-bit direction vector
  // An all-zero vector means no permitted port
  typedef enum logic [2:0] {
    PORT_N = 3'd0,
    PORT_E = 3'd1,
    PORT_W = 3'd2,
    PORT_S = 3'd3,
    PORT_L = 3'd4
  } portIdxT;

endpackage

`default_nettype wire

//--- hw/noc_macros.svh
// Address width must be even (x in the low half, y in the high half); FIFO depth a power of two
`ifndef NOC_MACROS_SVH
`define NOC_MACROS_SVH

// Node address width
// Low half holds x, high half holds y
`define NOC_ADDR_WIDTH 4

// Flit body width
// Must cover two addresses plus a non-empty tag
`define NOC_DATA_WIDTH 16

// Input buffer entries
// Power of two, at least 2
`define NOC_FIFO_DEPTH 4

`endif
